//--- hdl/lsu_pkg.sv
/*
 * Shared constants and types for the load/store unit data-memory pipeline.
 * Every RTL block refers to these by scoped name.
 */
`default_nettype none

package lsu_pkg;

   // ******************************************************************
   // Basic types
   // ******************************************************************
   typedef logic [31:0]        data_t;       // Data word
   typedef logic [31:0]        addr_t;       // Byte address
   typedef logic signed [11:0] offset_t;     // Immediate offset from the instruction
   typedef logic [7:0]         word_addr_t;  // DCCM word index
   typedef logic [3:0]         byteen_t;     // One enable per byte lane

   // ******************************************************************
   // Region and sizing
   // ******************************************************************
   localparam addr_t DCCM_BASE      = 32'hF004_0000;  // Start of the DCCM window
   localparam int    DCCM_ADDR_BITS = 10;             // 1 KB window
   localparam int    DCCM_WORDS     = 256;            // Array depth in words
   localparam int    STBUF_DEPTH    = 4;              // Store buffer entries
   localparam int    STBUF_PTR_BITS = 2;              // Enough to index STBUF_DEPTH

   // Access size, encoded like funct3[1:0] of the load/store opcodes
   typedef enum logic [1:0] {
      LSU_SIZE_B = 2'd0,
      LSU_SIZE_H = 2'd1,
      LSU_SIZE_W = 2'd2
   } lsu_size_e;

   // Control packet that walks down dc2 and dc3
   typedef struct packed {
      logic      valid;
      logic      store;     // 0 for loads
      lsu_size_e size;
      logic      unsign;    // Zero extend instead of sign extend
      logic      error;     // Misaligned or outside the DCCM
   } lsu_pkt_t;

   // One buffered store, already steered onto its byte lanes
   typedef struct packed {
      word_addr_t waddr;
      byteen_t    byteen;
      data_t      data;
   } stbuf_entry_t;

   // Access error report
   typedef struct packed {
      logic  valid;         // One cycle pulse
      logic  store;
      addr_t addr;          // Faulting effective address
   } lsu_error_t;

endpackage

`default_nettype wire

//--- hdl/lsu_addr_stage.sv
/*
 * Address stage. Forms the effective address, checks region and alignment,
 * steers store data onto its byte lanes and registers everything into dc2.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_stage (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        req_valid,     // One strobe per access
   input  wire                        req_store,
   input  wire lsu_pkg::lsu_size_e    req_size,
   input  wire                        req_unsign,
   input  wire lsu_pkg::addr_t        rs1,           // Base register
   input  wire lsu_pkg::offset_t      offset,
   input  wire lsu_pkg::data_t        store_data,
   input  wire                        store_stall,   // From the store buffer
   output lsu_pkg::lsu_pkt_t          pkt_dc2,
   output lsu_pkg::addr_t             addr_dc2,
   output lsu_pkg::stbuf_entry_t      st_entry_dc2
);

   lsu_pkg::addr_t        ea;            // Effective address
   logic                  in_dccm;
   logic                  misaligned;
   logic                  accept;
   lsu_pkg::byteen_t      byteen;
   lsu_pkg::data_t        lane_data;
   lsu_pkg::lsu_pkt_t     pkt_d;
   lsu_pkg::stbuf_entry_t entry_d;

   // ******************************************************************
   // Address generation and checks
   // ******************************************************************
   assign ea = rs1 + {{20{offset[11]}}, offset};   // Sign extend imm12

   // Upper bits have to match the window base
   assign in_dccm = (ea >> lsu_pkg::DCCM_ADDR_BITS) ==
                    (lsu_pkg::DCCM_BASE >> lsu_pkg::DCCM_ADDR_BITS);

   always_comb begin
      misaligned = 1'b0;
      byteen     = 4'b1111;
      case (req_size)
         lsu_pkg::LSU_SIZE_B: begin
            byteen = 4'b0001 << ea[1:0];      // Any byte is aligned
         end
         lsu_pkg::LSU_SIZE_H: begin
            misaligned = ea[0];
            byteen     = 4'b0011 << ea[1:0];
         end
         default: begin
            misaligned = |ea[1:0];            // Word needs both low bits clear
         end
      endcase
   end

   // Store data moves up to the lane of its first byte
   assign lane_data = store_data << {ea[1:0], 3'b000};

   // A store under stall is dropped here, loads always go
   assign accept = req_valid & ~(req_store & store_stall);

   assign pkt_d = '{valid:  accept,
                    store:  req_store,
                    size:   req_size,
                    unsign: req_unsign,
                    error:  ~in_dccm | misaligned};

   assign entry_d = '{waddr:  ea[lsu_pkg::DCCM_ADDR_BITS-1:2],
                      byteen: byteen,
                      data:   lane_data};

   // ******************************************************************
   // dc2 registers
   // ******************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_dc2 <= '0;
      end else begin
         pkt_dc2 <= pkt_d;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_dc2     <= ea;
         st_entry_dc2 <= entry_d;            // Only consumed for good stores
      end
   end

endmodule

`default_nettype wire

//--- hdl/lsu_stbuf.sv
/*
 * Store buffer. Circular FIFO of lane-aligned stores that forwards bytes
 * to loads in dc2 and drains one entry per cycle into the DCCM array.
 * Also computes the store stall level used by the address stage.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_stbuf (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire lsu_pkg::lsu_pkt_t         pkt_dc2,
   input  wire lsu_pkg::stbuf_entry_t     st_entry_dc2,
   input  wire lsu_pkg::addr_t            addr_dc2,
   output lsu_pkg::byteen_t               fwd_byteen,   // Lanes supplied by the buffer
   output lsu_pkg::data_t                 fwd_data,
   output logic                           drain_valid,  // Level, high while not empty
   output lsu_pkg::stbuf_entry_t          drain_entry,  // Oldest entry
   output logic                           store_stall,
   output logic                           stbuf_empty
);

   lsu_pkg::stbuf_entry_t                 mem [lsu_pkg::STBUF_DEPTH];
   logic [lsu_pkg::STBUF_PTR_BITS-1:0]    wr_ptr;
   logic [lsu_pkg::STBUF_PTR_BITS-1:0]    rd_ptr;
   logic [lsu_pkg::STBUF_PTR_BITS:0]      count;        // 0 .. STBUF_DEPTH
   logic                                  push;
   logic                                  pop;
   lsu_pkg::word_addr_t                   ld_waddr;

   // ******************************************************************
   // Push, pop and occupancy
   // ******************************************************************
   assign push = pkt_dc2.valid & pkt_dc2.store & ~pkt_dc2.error;   // Good store ends dc2
   assign pop  = drain_valid;                  // Array write always accepted

   assign stbuf_empty = (count == '0);
   assign drain_valid = ~stbuf_empty;
   assign drain_entry = mem[rd_ptr];

   // Entries held plus the store still in dc2 would fill the buffer
   assign store_stall = (int'(count) + int'(push)) >= lsu_pkg::STBUF_DEPTH;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;       // Wraps with the depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= st_entry_dc2;
      end
   end

   // ******************************************************************
   // Byte forwarding to the load in dc2
   // ******************************************************************
   assign ld_waddr = addr_dc2[lsu_pkg::DCCM_ADDR_BITS-1:2];

   // Walk oldest to youngest so a later match overrides an earlier one
   always_comb begin : fwd_search
      logic [lsu_pkg::STBUF_PTR_BITS-1:0] idx;
      fwd_byteen = '0;
      fwd_data   = '0;
      idx        = rd_ptr;
      for (int i = 0; i < lsu_pkg::STBUF_DEPTH; i++) begin
         idx = rd_ptr + i[lsu_pkg::STBUF_PTR_BITS-1:0];
         if ((i < int'(count)) && (mem[idx].waddr == ld_waddr)) begin
            for (int b = 0; b < 4; b++) begin
               if (mem[idx].byteen[b]) begin
                  fwd_byteen[b]      = 1'b1;
                  fwd_data[8*b +: 8] = mem[idx].data[8*b +: 8];
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/lsu_dccm_ctl.sv
/*
 * DCCM control. Holds the data array, writes drained stores, reads for dc2
 * loads and in dc3 merges forwarded bytes, aligns and extends the result.
 * Access errors are reported from dc3 instead of a load result.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_dccm_ctl (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire lsu_pkg::lsu_pkt_t       pkt_dc2,
   input  wire lsu_pkg::addr_t          addr_dc2,
   input  wire lsu_pkg::byteen_t        fwd_byteen,
   input  wire lsu_pkg::data_t          fwd_data,
   input  wire                          drain_valid,
   input  wire lsu_pkg::stbuf_entry_t   drain_entry,
   output logic                         load_valid,    // Pulse in dc3
   output lsu_pkg::data_t               load_data,
   output lsu_pkg::lsu_error_t          access_error,
   output logic                         busy_dc3
);

   lsu_pkg::data_t       dccm_mem [lsu_pkg::DCCM_WORDS];
   lsu_pkg::lsu_pkt_t    pkt_dc3;
   lsu_pkg::addr_t       addr_dc3;
   lsu_pkg::data_t       rd_data_dc3;       // Raw array word
   lsu_pkg::byteen_t     fwd_byteen_dc3;
   lsu_pkg::data_t       fwd_data_dc3;
   lsu_pkg::data_t       merged_dc3;
   lsu_pkg::data_t       shifted_dc3;
   logic                 rd_en_dc2;
   lsu_pkg::word_addr_t  rd_waddr;

   // ******************************************************************
   // Array: byte-enable write from the drain, synchronous read
   // ******************************************************************
   assign rd_en_dc2 = pkt_dc2.valid & ~pkt_dc2.store & ~pkt_dc2.error;
   assign rd_waddr  = addr_dc2[lsu_pkg::DCCM_ADDR_BITS-1:2];

   always_ff @(posedge clk) begin
      if (drain_valid) begin
         for (int b = 0; b < 4; b++) begin
            if (drain_entry.byteen[b]) begin
               dccm_mem[drain_entry.waddr][8*b +: 8] <= drain_entry.data[8*b +: 8];
            end
         end
      end
   end

   // Same edge as a drain write, so this sees the old word
   always_ff @(posedge clk) begin
      if (rd_en_dc2) begin
         rd_data_dc3 <= dccm_mem[rd_waddr];
      end
   end

   // ******************************************************************
   // dc3 registers
   // ******************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_dc3 <= '0;
      end else begin
         pkt_dc3 <= pkt_dc2;
      end
   end

   always_ff @(posedge clk) begin
      if (pkt_dc2.valid) begin
         addr_dc3       <= addr_dc2;
         fwd_byteen_dc3 <= fwd_byteen;     // Includes an entry draining now
         fwd_data_dc3   <= fwd_data;
      end
   end

   // Buffered bytes are younger than the array
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged_dc3[8*b +: 8] = fwd_byteen_dc3[b] ? fwd_data_dc3[8*b +: 8]
                                                  : rd_data_dc3[8*b +: 8];
      end
   end

   assign shifted_dc3 = merged_dc3 >> {addr_dc3[1:0], 3'b000};   // Addressed byte to lane 0

   always_comb begin
      case (pkt_dc3.size)
         lsu_pkg::LSU_SIZE_B: load_data = pkt_dc3.unsign ? {24'b0, shifted_dc3[7:0]}
                                         : {{24{shifted_dc3[7]}}, shifted_dc3[7:0]};
         lsu_pkg::LSU_SIZE_H: load_data = pkt_dc3.unsign ? {16'b0, shifted_dc3[15:0]}
                                         : {{16{shifted_dc3[15]}}, shifted_dc3[15:0]};
         default:             load_data = shifted_dc3;
      endcase
   end

   // ******************************************************************
   // Results
   // ******************************************************************
   assign load_valid   = pkt_dc3.valid & ~pkt_dc3.store & ~pkt_dc3.error;
   assign access_error = '{valid: pkt_dc3.valid & pkt_dc3.error,
                           store: pkt_dc3.store,
                           addr:  addr_dc3};
   assign busy_dc3     = pkt_dc3.valid;

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
/*
 * Load/store unit data-memory top level. Connects the address stage, the
 * store buffer and the DCCM control and derives the idle flag.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        req_valid,
   input  wire                        req_store,
   input  wire lsu_pkg::lsu_size_e    req_size,
   input  wire                        req_unsign,
   input  wire lsu_pkg::addr_t        rs1,
   input  wire lsu_pkg::offset_t      offset,
   input  wire lsu_pkg::data_t        store_data,
   output logic                       load_valid,
   output lsu_pkg::data_t             load_data,
   output lsu_pkg::lsu_error_t        access_error,
   output logic                       store_stall,   // Hold off stores while high
   output logic                       idle
);

   lsu_pkg::lsu_pkt_t      pkt_dc2;
   lsu_pkg::addr_t         addr_dc2;
   lsu_pkg::stbuf_entry_t  st_entry_dc2;
   lsu_pkg::byteen_t       fwd_byteen;
   lsu_pkg::data_t         fwd_data;
   logic                   drain_valid;
   lsu_pkg::stbuf_entry_t  drain_entry;
   logic                   stbuf_empty;
   logic                   busy_dc3;

   // ******************************************************************
   // Pipeline stages
   // ******************************************************************
   lsu_addr_stage u_addr_stage (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_store    (req_store),
      .req_size     (req_size),
      .req_unsign   (req_unsign),
      .rs1          (rs1),
      .offset       (offset),
      .store_data   (store_data),
      .store_stall  (store_stall),
      .pkt_dc2      (pkt_dc2),
      .addr_dc2     (addr_dc2),
      .st_entry_dc2 (st_entry_dc2)
   );

   lsu_stbuf u_stbuf (
      .clk          (clk),
      .rst_n        (rst_n),
      .pkt_dc2      (pkt_dc2),
      .st_entry_dc2 (st_entry_dc2),
      .addr_dc2     (addr_dc2),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data),
      .drain_valid  (drain_valid),
      .drain_entry  (drain_entry),
      .store_stall  (store_stall),
      .stbuf_empty  (stbuf_empty)
   );

   lsu_dccm_ctl u_dccm_ctl (
      .clk          (clk),
      .rst_n        (rst_n),
      .pkt_dc2      (pkt_dc2),
      .addr_dc2     (addr_dc2),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data),
      .drain_valid  (drain_valid),
      .drain_entry  (drain_entry),
      .load_valid   (load_valid),
      .load_data    (load_data),
      .access_error (access_error),
      .busy_dc3     (busy_dc3)
   );

   // Nothing in flight and nothing left to drain
   assign idle = ~pkt_dc2.valid & ~busy_dc3 & stbuf_empty;

endmodule

`default_nettype wire

//--- testbench/lsu_chk.sv
/*
 * Timing and exclusivity assertions for the LSU top level, bound into lsu_top.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_chk (
   input wire                       clk,
   input wire                       rst_n,
   input wire                       req_valid,
   input wire                       req_store,
   input wire                       load_valid,
   input wire lsu_pkg::lsu_error_t  access_error,
   input wire                       store_stall,
   input wire                       idle
);

   int quiet_cycles;                                        // Edges since the last request
   int n_assert_fail = 0;                                   // Failed assertions for the summary

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         quiet_cycles <= 0;
      end else if (req_valid) begin
         quiet_cycles <= 0;
      end else if (quiet_cycles < 1000) begin
         quiet_cycles <= quiet_cycles + 1;                  // Saturates well above the idle limit
      end
   end

   // A result is sampled two edges after its request was sampled
   a_load_latency: assert property (@(posedge clk) disable iff (!rst_n)
      load_valid |-> $past(req_valid && !req_store, 2))
      else begin
         n_assert_fail++;
         $error("load_valid without a load request two edges earlier");
      end
   a_error_latency: assert property (@(posedge clk) disable iff (!rst_n)
      access_error.valid |-> $past(req_valid, 2))
      else begin
         n_assert_fail++;
         $error("access_error without a request two edges earlier");
      end
   a_load_answered: assert property (@(posedge clk) disable iff (!rst_n)
      $past(req_valid && !req_store, 2) |-> (load_valid || access_error.valid))
      else begin
         n_assert_fail++;
         $error("Load request got neither data nor an error");
      end
   a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(load_valid && access_error.valid))
      else begin
         n_assert_fail++;
         $error("load_valid and access_error high together");
      end
   a_no_store_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
      !(req_valid && req_store && store_stall))
      else begin
         n_assert_fail++;
         $error("Store presented while store_stall was high");
      end

   // Idle with quiet outputs right after reset, idle again once the pipe and buffer empty
   a_idle_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> (idle && !store_stall && !load_valid && !access_error.valid))
      else begin
         n_assert_fail++;
         $error("Outputs not at their reset values after reset");
      end
   a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      (quiet_cycles >= lsu_pkg::STBUF_DEPTH + 3) |-> idle)
      else begin
         n_assert_fail++;
         $error("Not idle long after the last request");
      end

endmodule

bind lsu_top lsu_chk i_chk (
   .clk          (clk),
   .rst_n        (rst_n),
   .req_valid    (req_valid),
   .req_store    (req_store),
   .load_valid   (load_valid),
   .access_error (access_error),
   .store_stall  (store_stall),
   .idle         (idle)
);

`default_nettype wire

//--- testbench/lsu_tb.sv
/*
 * Testbench for the LSU data-memory pipeline. Issues random loads and stores
 * against a byte model of the DCCM and checks every load result and error.
 * Latency, exclusivity and idle rules come from the bound lsu_chk module.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

   localparam int NUM_INIT  = 8;                            // One word store per hot word
   localparam int NUM_RAND  = 400;
   localparam int NUM_BURST = 16;
   localparam int NUM_REQ   = NUM_INIT + NUM_RAND + 2 * NUM_BURST;
   localparam lsu_pkg::word_addr_t POOL [8] = '{8'h00, 8'h01, 8'h02, 8'h03,
                                                8'h40, 8'h41, 8'hFE, 8'hFF};

   typedef struct packed {
      logic           err;
      logic           store;
      lsu_pkg::addr_t addr;
      lsu_pkg::data_t data;                                 // Expected load value
   } expect_t;

   logic                clk;
   logic                rst_n;
   logic                req_valid;
   logic                req_store;
   lsu_pkg::lsu_size_e  req_size;
   logic                req_unsign;
   lsu_pkg::addr_t      rs1;
   lsu_pkg::offset_t    offset;
   lsu_pkg::data_t      store_data;
   logic                load_valid;
   lsu_pkg::data_t      load_data;
   lsu_pkg::lsu_error_t access_error;
   logic                store_stall;
   logic                idle;

   logic [7:0] model [1 << lsu_pkg::DCCM_ADDR_BITS];      // Byte image of the DCCM
   expect_t    exp_q [$];                                   // Results in request order
   int         n_checks;
   int         n_value_err;
   int         n_other_err;

   lsu_top i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_store    (req_store),
      .req_size     (req_size),
      .req_unsign   (req_unsign),
      .rs1          (rs1),
      .offset       (offset),
      .store_data   (store_data),
      .load_valid   (load_valid),
      .load_data    (load_data),
      .access_error (access_error),
      .store_stall  (store_stall),
      .idle         (idle)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                                // 4 ns period
   end

   // ******************************************************************
   // Reference rules
   // ******************************************************************
   function automatic logic in_region(input lsu_pkg::addr_t a);
      return (a >= lsu_pkg::DCCM_BASE) &&
             ((a - lsu_pkg::DCCM_BASE) < (32'd1 << lsu_pkg::DCCM_ADDR_BITS));
   endfunction

   function automatic int size_bytes(input lsu_pkg::lsu_size_e sz);
      case (sz)
         lsu_pkg::LSU_SIZE_B: return 1;
         lsu_pkg::LSU_SIZE_H: return 2;
         default:             return 4;
      endcase
   endfunction

   // Little endian gather and then sign or zero fill above the access
   function automatic lsu_pkg::data_t model_load(input lsu_pkg::addr_t a,
                                                 input lsu_pkg::lsu_size_e sz, input logic uns);
      lsu_pkg::data_t v;
      logic [7:0]     top;
      int             n;
      int             idx;
      v   = '0;
      n   = size_bytes(sz);
      idx = int'(a - lsu_pkg::DCCM_BASE);
      for (int k = 0; k < n; k++) begin
         v[8*k +: 8] = model[10'(idx + k)];
      end
      top = model[10'(idx + n - 1)];                        // Holds the sign bit
      if (!uns && top[7]) begin
         for (int k = n; k < 4; k++) begin
            v[8*k +: 8] = 8'hFF;
         end
      end
      return v;
   endfunction

   function automatic void model_store(input lsu_pkg::addr_t a, input lsu_pkg::lsu_size_e sz,
                                       input lsu_pkg::data_t d);
      int idx;
      idx = int'(a - lsu_pkg::DCCM_BASE);
      for (int k = 0; k < size_bytes(sz); k++) begin
         model[10'(idx + k)] = d[8*k +: 8];                 // Low byte goes to the lowest address
      end
   endfunction

   function automatic lsu_pkg::addr_t hot_word();
      return lsu_pkg::DCCM_BASE + {22'b0, POOL[3'($urandom_range(0, 7))], 2'b00};
   endfunction

   // Mostly hot words so the buffer forwards and a few addresses outside the window
   function automatic lsu_pkg::addr_t pick_addr();
      int r;
      r = $urandom_range(0, 19);
      if (r == 0) return {1'b0, 31'($urandom)};            // Far outside the window
      if (r == 1) return lsu_pkg::DCCM_BASE - 32'($urandom_range(1, 8));
      if (r == 2) return lsu_pkg::DCCM_BASE + 32'h400 + 32'($urandom_range(0, 7));
      return hot_word() + 32'($urandom_range(0, 3));
   endfunction

   // ******************************************************************
   // Drive and check
   // ******************************************************************
   task automatic issue(input logic st, input lsu_pkg::lsu_size_e sz, input logic uns,
                        input lsu_pkg::addr_t ea, input lsu_pkg::data_t sd);
      lsu_pkg::offset_t off;
      logic             bad;
      expect_t          e;
      off = lsu_pkg::offset_t'($urandom);
      bad = !in_region(ea) || ((ea % 32'(size_bytes(sz))) != 0);
      @(posedge clk);
      while (st && store_stall) begin                       // Hold the store back
         req_valid <= 1'b0;
         @(posedge clk);
      end
      req_valid  <= 1'b1;
      req_store  <= st;
      req_size   <= sz;
      req_unsign <= uns;
      rs1        <= ea - {{20{off[11]}}, off};              // Base chosen so base + imm hits ea
      offset     <= off;
      store_data <= sd;
      e = '{err: bad, store: st, addr: ea, data: '0};
      if (!bad && st) begin
         model_store(ea, sz, sd);
      end else if (!bad) begin
         e.data = model_load(ea, sz, uns);
      end
      if (bad || !st) begin
         exp_q.push_back(e);                                // Good stores answer nothing
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   task automatic value_error(input string what, input lsu_pkg::data_t got,
                              input lsu_pkg::data_t expected);
      n_value_err++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, expected);
   endtask

   always @(posedge clk) begin : result_check
      expect_t e;
      if (rst_n && (load_valid || access_error.valid)) begin
         if (exp_q.size() == 0) begin
            n_other_err++;
            $display("A result came out at %0t ns with no access outstanding", $time);
         end else begin
            e = exp_q.pop_front();
            n_checks++;
            assert (access_error.valid == e.err && load_valid == !e.err)
               else value_error("result kind (1 = error)", {31'b0, access_error.valid},
                                {31'b0, e.err});
            if (e.err) begin
               assert (access_error.addr == e.addr)
                  else value_error("error address", access_error.addr, e.addr);
               assert (access_error.store == e.store)
                  else value_error("error store flag", {31'b0, access_error.store},
                                   {31'b0, e.store});
            end else begin
               assert (load_data === e.data)
                  else value_error("load data", load_data, e.data);
            end
         end
      end
   end

   // ******************************************************************
   // Stimulus
   // ******************************************************************
   initial begin : stimulus
      logic               st;
      lsu_pkg::lsu_size_e sz;
      void'($urandom(32'h270b28c2));
      n_checks    = 0;
      n_value_err = 0;
      n_other_err = 0;
      rst_n       = 1'b0;
      req_valid   = 1'b0;
      req_store   = 1'b0;
      req_size    = lsu_pkg::LSU_SIZE_W;
      req_unsign  = 1'b0;
      rs1         = '0;
      offset      = '0;
      store_data  = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < NUM_INIT; i++) begin             // Known contents in every hot word
         issue(1'b1, lsu_pkg::LSU_SIZE_W, 1'b0,
               lsu_pkg::DCCM_BASE + {22'b0, POOL[i], 2'b00}, $urandom);
      end

      for (int i = 0; i < NUM_RAND; i++) begin
         st = ($urandom_range(0, 2) == 0);
         sz = lsu_pkg::lsu_size_e'($urandom_range(0, 2));
         issue(st, sz, 1'($urandom_range(0, 1)), pick_addr(), $urandom);
         if ($urandom_range(0, 3) == 0) begin
            idle_cycles(1);
         end
      end

      // Back to back stores and then reads of the hot words
      for (int i = 0; i < NUM_BURST; i++) begin
         issue(1'b1, lsu_pkg::LSU_SIZE_W, 1'b0, hot_word(), $urandom);
      end
      for (int i = 0; i < NUM_BURST; i++) begin
         sz = lsu_pkg::lsu_size_e'($urandom_range(0, 2));
         issue(1'b0, sz, 1'($urandom_range(0, 1)),
               hot_word() + 32'($urandom_range(0, 3)), '0);
      end
      idle_cycles(1);

      while (exp_q.size() != 0) @(posedge clk);
      repeat (lsu_pkg::STBUF_DEPTH + 3) @(posedge clk);
      assert (idle) else begin
         n_other_err++;
         $display("The DUT is not idle after the last access finished");
      end

      $display("Checks run: %0d, value errors: %0d, other errors: %0d, assertion errors: %0d",
               n_checks, n_value_err, n_other_err, i_dut.i_chk.n_assert_fail);
      if (n_value_err == 0 && n_other_err == 0 && i_dut.i_chk.n_assert_fail == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (NUM_REQ * 4 + 200) @(posedge clk);
      $display("Watchdog expired with %0d results still outstanding", exp_q.size());
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
hdl/lsu_pkg.sv
hdl/lsu_addr_stage.sv
hdl/lsu_stbuf.sv
hdl/lsu_dccm_ctl.sv
hdl/lsu_top.sv
testbench/lsu_chk.sv
testbench/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module lsu_tb -f compile.f -o lsu_sim \
   > build.log 2>&1 &&
./obj_dir/lsu_sim > sim.log 2>&1 ||
{ cat build.log; echo "Test failed" >> sim.log; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
